// File: vec_pkg.sv
////////////////////////////////////////
// SEW fixed at 32 bits, no masking by v0
// vl and vstart never exceed VLMAX
////////////////////////////////////////
package vec_pkg;

  // sizes
  localparam int NUM_LANES  = 2;  // elements per beat
  localparam int VLMAX      = 8;  // elements per vector register
  localparam int NUM_VREGS  = 8;
  localparam int NUM_ROWS   = VLMAX / NUM_LANES;  // beat-wide rows per register
  localparam int LANE_SHIFT = $clog2(NUM_LANES);  // offset to row index

  typedef logic [31:0]                   elem_t;
  typedef logic [$clog2(NUM_VREGS)-1:0]  vreg_idx_t;
  typedef logic [$clog2(VLMAX):0]        offset_t;   // one extra bit so VLMAX fits
  typedef logic [$clog2(NUM_ROWS)-1:0]   row_idx_t;
  typedef elem_t [NUM_LANES-1:0]         row_t;      // lane 0 in the low word
  typedef logic [NUM_LANES-1:0]          lane_mask_t;

  // .vv forms compute vs2 op vs1, .vx forms vs2 op scalar
  typedef enum logic [2:0] {
    VOP_VID     = 3'd0,  // index + scalar
    VOP_VMV_VX  = 3'd1,  // splat scalar
    VOP_VADD_VV = 3'd2,
    VOP_VSUB_VV = 3'd3,
    VOP_VAND_VV = 3'd4,
    VOP_VOR_VV  = 3'd5,
    VOP_VXOR_VV = 3'd6,
    VOP_VADD_VX = 3'd7
  } vop_e;

  typedef struct packed {
    vop_e       op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_t      scalar;
    offset_t    vstart;  // first element written
    offset_t    vl;      // elements at or above vl untouched
  } vec_cmd_t;

  typedef struct packed {
    vop_e       op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_t      scalar;
    offset_t    offset;     // element index of lane 0
    lane_mask_t lane_mask;  // lanes to write
    logic       last;       // final beat of the instruction
  } vec_beat_t;

  typedef struct packed {
    vreg_idx_t  vd;
    offset_t    offset;
    row_t       data;
    lane_mask_t lane_mask;
    logic       last;
  } vec_result_t;

endpackage

// File: vec_elem_seq.sv
////////////////////////////////////////
// one command at a time, accepted only when the
// pipeline is empty; empty commands give no beats
////////////////////////////////////////
`timescale 1ns/1ps

module vec_elem_seq (
  input  logic               CLK,
  input  logic               nRST,
  input  vec_pkg::vec_cmd_t  cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  logic               advance,     // low stalls everything
  input  logic               pipe_empty,  // no beat in later stages
  output vec_pkg::vec_beat_t beat,
  output logic               beat_valid
);
  import vec_pkg::*;

  typedef enum logic {
    S_IDLE,
    S_RUN
  } seq_state_e;

  seq_state_e state;
  vec_cmd_t   cmd_q;      // held for the whole instruction
  offset_t    cur_off;    // lane 0 index of the next beat
  offset_t    next_off;
  offset_t    lane_idx;
  offset_t    start_off;
  lane_mask_t lane_mask;
  logic       cmd_fire;
  logic       cmd_empty;
  logic       last_beat;

  assign cmd_ready = (state == S_IDLE) & pipe_empty;
  assign cmd_fire  = cmd_valid & cmd_ready;

  // nothing to do when vl is 0 or vstart already past it
  assign cmd_empty = (cmd.vl == '0) | (cmd.vstart >= cmd.vl);

  // vstart rounded down to a beat boundary
  assign start_off = cmd.vstart & ~offset_t'(NUM_LANES - 1);

  assign next_off  = cur_off + offset_t'(NUM_LANES);
  assign last_beat = next_off >= cmd_q.vl;  // this beat reaches vl

  // lanes outside [vstart, vl) stay undisturbed
  always_comb begin
    lane_idx  = cur_off;
    lane_mask = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_idx     = cur_off + offset_t'(i);
      lane_mask[i] = (lane_idx >= cmd_q.vstart) && (lane_idx < cmd_q.vl);
    end
  end

  // state, offset and valid
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= S_IDLE;
      cur_off    <= '0;
      beat_valid <= 1'b0;
    end else if (advance) begin
      case (state)
        S_IDLE: begin
          beat_valid <= 1'b0;  // drain the last beat
          if (cmd_fire && !cmd_empty) begin
            state   <= S_RUN;
            cur_off <= start_off;
          end
        end
        S_RUN: begin
          beat_valid <= 1'b1;
          cur_off    <= next_off;  // step by NUM_LANES
          if (last_beat) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // command and beat payload
  always_ff @(posedge CLK) begin
    if (cmd_fire) begin
      cmd_q <= cmd;
    end
    if (advance && state == S_RUN) begin
      beat.op        <= cmd_q.op;
      beat.vd        <= cmd_q.vd;
      beat.vs1       <= cmd_q.vs1;
      beat.vs2       <= cmd_q.vs2;
      beat.scalar    <= cmd_q.scalar;
      beat.offset    <= cur_off;
      beat.lane_mask <= lane_mask;
      beat.last      <= last_beat;
    end
  end

endmodule

// File: vec_regfile.sv
////////////////////////////////////////
// rows are NUM_LANES wide and beat aligned
// same-cycle write data bypasses to the reads
////////////////////////////////////////
`timescale 1ns/1ps

module vec_regfile (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 advance,
  input  vec_pkg::vec_beat_t   beat_in,
  input  logic                 beat_in_valid,
  output vec_pkg::vec_beat_t   beat_out,
  output logic                 beat_out_valid,
  output vec_pkg::row_t        row_a,   // vs1
  output vec_pkg::row_t        row_b,   // vs2
  input  vec_pkg::vec_result_t wr,
  input  logic                 wr_en
);
  import vec_pkg::*;

  row_t     mem [NUM_VREGS][NUM_ROWS];
  row_idx_t rd_row;
  row_idx_t wr_row;
  logic     hit_a;
  logic     hit_b;
  row_t     rd_a;
  row_t     rd_b;

  // masked lanes of new data over an old row
  function automatic row_t merge_row(row_t old_row, logic hit, row_t data, lane_mask_t mask);
    row_t r;
    r = old_row;
    if (hit) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (mask[i]) begin
          r[i] = data[i];
        end
      end
    end
    return r;
  endfunction

  assign rd_row = row_idx_t'(beat_in.offset >> LANE_SHIFT);
  assign wr_row = row_idx_t'(wr.offset >> LANE_SHIFT);

  // read hits the row written this cycle
  assign hit_a = wr_en && (wr.vd == beat_in.vs1) && (wr_row == rd_row);
  assign hit_b = wr_en && (wr.vd == beat_in.vs2) && (wr_row == rd_row);

  assign rd_a = merge_row(mem[beat_in.vs1][rd_row], hit_a, wr.data, wr.lane_mask);
  assign rd_b = merge_row(mem[beat_in.vs2][rd_row], hit_b, wr.data, wr.lane_mask);

  // storage, all registers start at zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int v = 0; v < NUM_VREGS; v++) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
          mem[v][r] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr.vd][wr_row] <= merge_row(mem[wr.vd][wr_row], 1'b1, wr.data, wr.lane_mask);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      beat_out_valid <= 1'b0;
    end else if (advance) begin
      beat_out_valid <= beat_in_valid;
    end
  end

  // rows travel with their beat
  always_ff @(posedge CLK) begin
    if (advance) begin
      beat_out <= beat_in;
      row_a    <= rd_a;
      row_b    <= rd_b;
    end
  end

endmodule

// File: vec_lane_alu.sv
////////////////////////////////////////
// 32-bit lanes, arithmetic wraps
////////////////////////////////////////
`timescale 1ns/1ps

module vec_lane_alu (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 advance,
  input  vec_pkg::vec_beat_t   beat,
  input  logic                 beat_valid,
  input  vec_pkg::row_t        row_a,   // vs1 elements
  input  vec_pkg::row_t        row_b,   // vs2 elements
  output vec_pkg::vec_result_t res,
  output logic                 res_valid
);
  import vec_pkg::*;

  row_t  lane_res;
  elem_t lane_idx;

  // one result per lane
  always_comb begin
    lane_res = '0;
    lane_idx = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_idx = elem_t'(beat.offset) + elem_t'(i);  // element index of this lane
      case (beat.op)
        VOP_VID:     lane_res[i] = lane_idx + beat.scalar;
        VOP_VMV_VX:  lane_res[i] = beat.scalar;
        VOP_VADD_VV: lane_res[i] = row_b[i] + row_a[i];
        VOP_VSUB_VV: lane_res[i] = row_b[i] - row_a[i];  // vs2 - vs1
        VOP_VAND_VV: lane_res[i] = row_b[i] & row_a[i];
        VOP_VOR_VV:  lane_res[i] = row_b[i] | row_a[i];
        VOP_VXOR_VV: lane_res[i] = row_b[i] ^ row_a[i];
        VOP_VADD_VX: lane_res[i] = row_b[i] + beat.scalar;
        default:     lane_res[i] = '0;
      endcase
    end
  end

  // output stage valid
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res_valid <= 1'b0;
    end else if (advance) begin
      res_valid <= beat_valid;
    end
  end

  // output stage payload, held under back-pressure
  always_ff @(posedge CLK) begin
    if (advance) begin
      res.vd        <= beat.vd;
      res.offset    <= beat.offset;
      res.data      <= lane_res;
      res.lane_mask <= beat.lane_mask;
      res.last      <= beat.last;
    end
  end

endmodule

// File: vec_exec_top.sv
////////////////////////////////////////
// res_ready low stalls the whole pipeline
// results write back as they leave
////////////////////////////////////////
`timescale 1ns/1ps

module vec_exec_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vec_pkg::vec_cmd_t    cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  output vec_pkg::vec_result_t res,
  output logic                 res_valid,
  input  logic                 res_ready
);
  import vec_pkg::*;

  vec_beat_t seq_beat;       // sequencer to register file
  logic      seq_beat_valid;
  vec_beat_t rf_beat;        // register file to ALU
  logic      rf_beat_valid;
  row_t      row_a;
  row_t      row_b;
  logic      advance;
  logic      pipe_empty;
  logic      wr_en;

  // only a stuck result stalls
  assign advance    = ~res_valid | res_ready;
  assign pipe_empty = ~seq_beat_valid & ~rf_beat_valid & ~res_valid;
  assign wr_en      = res_valid & res_ready;  // write on the result handshake

  vec_elem_seq i_seq (
    .CLK        (CLK),
    .nRST       (nRST),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .advance    (advance),
    .pipe_empty (pipe_empty),
    .beat       (seq_beat),
    .beat_valid (seq_beat_valid)
  );

  vec_regfile i_rf (
    .CLK            (CLK),
    .nRST           (nRST),
    .advance        (advance),
    .beat_in        (seq_beat),
    .beat_in_valid  (seq_beat_valid),
    .beat_out       (rf_beat),
    .beat_out_valid (rf_beat_valid),
    .row_a          (row_a),
    .row_b          (row_b),
    .wr             (res),
    .wr_en          (wr_en)
  );

  vec_lane_alu i_alu (
    .CLK        (CLK),
    .nRST       (nRST),
    .advance    (advance),
    .beat       (rf_beat),
    .beat_valid (rf_beat_valid),
    .row_a      (row_a),
    .row_b      (row_b),
    .res        (res),
    .res_valid  (res_valid)
  );

endmodule

// File: tb_vec_exec.sv
////////////////////////////////////////
// checks every result beat against a shadow
// register model, one command in flight at a time
////////////////////////////////////////
`timescale 1ns/1ps

module tb_vec_exec;
  import vec_pkg::*;

  localparam int MAX_CYCLES = 4000;  // tests take ~800 cycles incl. stalls

  logic        CLK;
  logic        nRST;
  vec_cmd_t    cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  vec_result_t res;
  logic        res_valid;
  logic        res_ready;

  elem_t       shadow [NUM_VREGS][VLMAX];  // expected register contents
  vec_result_t expq [$];                   // beats still to arrive, in order
  vec_result_t exp_r;
  integer      seed;
  integer      bp_seed;                    // res_ready stalls
  logic        bp_on;
  int          errors;
  int          test_errs;                  // errors before the current test
  int          test_no;
  int          beats_checked;
  int          res_beats;                  // every result handshake, expected or not
  int          beats_before;
  int          cycles;

  vec_exec_top i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles, %0d beats never arrived", cycles, expq.size());
      $display("Errors found");
      $finish;
    end
  end

  // random back-pressure, about one stall in four
  always @(posedge CLK) begin
    #2;
    if (bp_on) begin
      res_ready = ($random(bp_seed) & 3) != 0;
    end else begin
      res_ready = 1'b1;
    end
  end

  task automatic report_error(input string msg);
    $display("Error %0t ns: %s", $time, msg);
    errors++;
  endtask

  // expected beat at one offset, from the shadow
  function automatic vec_result_t vec_ref(input vec_cmd_t c, input offset_t off);
    vec_result_t r;
    int          idx;
    elem_t       a;
    elem_t       b;
    r        = '0;
    r.vd     = c.vd;
    r.offset = off;
    r.last   = (int'(off) + NUM_LANES) >= int'(c.vl);  // reaches vl
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = int'(off) + i;
      a   = shadow[c.vs1][idx];
      b   = shadow[c.vs2][idx];
      r.lane_mask[i] = (idx >= int'(c.vstart)) && (idx < int'(c.vl));
      case (c.op)
        VOP_VID:     r.data[i] = elem_t'(idx) + c.scalar;
        VOP_VMV_VX:  r.data[i] = c.scalar;
        VOP_VADD_VV: r.data[i] = b + a;
        VOP_VSUB_VV: r.data[i] = b - a;  // vs2 minus vs1
        VOP_VAND_VV: r.data[i] = b & a;
        VOP_VOR_VV:  r.data[i] = b | a;
        VOP_VXOR_VV: r.data[i] = b ^ a;
        VOP_VADD_VX: r.data[i] = b + c.scalar;
        default:     r.data[i] = '0;
      endcase
    end
    return r;
  endfunction

  // whole instruction into the queue, shadow updated beat by beat
  task automatic queue_expected(input vec_cmd_t c);
    vec_result_t r;
    int          first;
    if (c.vl == '0 || c.vstart >= c.vl) begin
      return;  // no beats
    end
    first = (int'(c.vstart) / NUM_LANES) * NUM_LANES;
    for (int off = first; off < int'(c.vl); off += NUM_LANES) begin
      r = vec_ref(c, offset_t'(off));
      expq.push_back(r);
      for (int i = 0; i < NUM_LANES; i++) begin
        if (r.lane_mask[i]) begin
          shadow[c.vd][off + i] = r.data[i];
        end
      end
    end
  endtask

  task automatic check_beat(input vec_result_t e, input vec_result_t g);
    if (g.vd !== e.vd) begin
      report_error($sformatf("vd is %0d, expected %0d", g.vd, e.vd));
    end
    if (g.offset !== e.offset) begin
      report_error($sformatf("offset is %0d, expected %0d", g.offset, e.offset));
    end
    if (g.lane_mask !== e.lane_mask) begin
      report_error($sformatf("lane mask at offset %0d is %b, expected %b",
                             e.offset, g.lane_mask, e.lane_mask));
    end
    if (g.last !== e.last) begin
      report_error($sformatf("last at offset %0d is %b, expected %b", e.offset, g.last, e.last));
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (e.lane_mask[i] && g.data[i] !== e.data[i]) begin
        report_error($sformatf("v%0d[%0d] is %h, expected %h",
                               e.vd, int'(e.offset) + i, g.data[i], e.data[i]));
      end
    end
  endtask

  // handshake seen here completes on the next rising edge
  always @(negedge CLK) begin
    if (nRST && res_valid && res_ready) begin
      res_beats++;
      if (expq.size() == 0) begin
        $display("unexpected extra result beat at %0t ns for v%0d offset %0d",
                 $time, res.vd, res.offset);
        errors++;
      end else begin
        exp_r = expq.pop_front();
        check_beat(exp_r, res);
        beats_checked++;
      end
    end
    if (nRST && cmd_ready && expq.size() != 0) begin
      report_error("cmd_ready high while result beats are still in flight");
    end
  end

  function automatic vec_cmd_t make_cmd(input vop_e op, input int vd, input int vs1,
                                        input int vs2, input elem_t scalar,
                                        input int vstart, input int vl);
    vec_cmd_t c;
    c.op     = op;
    c.vd     = vreg_idx_t'(vd);
    c.vs1    = vreg_idx_t'(vs1);
    c.vs2    = vreg_idx_t'(vs2);
    c.scalar = scalar;
    c.vstart = offset_t'(vstart);
    c.vl     = offset_t'(vl);
    return c;
  endfunction

  // called at posedge + 2 ns, returns there after the handshake
  task automatic send_cmd(input vec_cmd_t c);
    logic fire;
    cmd       = c;
    cmd_valid = 1'b1;
    fire      = 1'b0;
    while (!fire) begin
      @(negedge CLK);
      fire = cmd_ready;
      @(posedge CLK);
      #2;
    end
    cmd_valid = 1'b0;  // a following send raises it again at once
    queue_expected(c);
  endtask

  task automatic send_random(input vop_e op, input int vstart, input int vl);
    int    vd;
    int    vs1;
    int    vs2;
    elem_t scalar;
    vd     = $random(seed) & (NUM_VREGS - 1);
    vs1    = $random(seed) & (NUM_VREGS - 1);
    vs2    = $random(seed) & (NUM_VREGS - 1);
    scalar = $random(seed);
    send_cmd(make_cmd(op, vd, vs1, vs2, scalar, vstart, vl));
  endtask

  // until the DUT is idle again
  task automatic wait_drain();
    do begin
      @(negedge CLK);
    end while (!cmd_ready);
    if (expq.size() != 0) begin
      $display("%0d expected result beats never arrived before %0t ns", expq.size(), $time);
      errors++;
      expq.delete();
    end
    @(posedge CLK);
    #2;
  endtask

  task automatic readback_all();
    for (int v = 0; v < NUM_VREGS; v++) begin
      send_cmd(make_cmd(VOP_VOR_VV, v, v, v, '0, 0, VLMAX));  // v | v keeps v
      wait_drain();
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s: %s", test_no, name, (errors == test_errs) ? "ok" : "failed");
    test_no++;
    test_errs = errors;
  endtask

  initial begin
    seed          = 32'hb048;
    bp_seed       = seed + 1;
    nRST          = 1'b0;
    cmd           = '0;
    cmd_valid     = 1'b0;
    res_ready     = 1'b1;
    bp_on         = 1'b0;
    errors        = 0;
    test_errs     = 0;
    test_no       = 1;
    beats_checked = 0;
    res_beats     = 0;
    for (int v = 0; v < NUM_VREGS; v++) begin
      for (int e = 0; e < VLMAX; e++) begin
        shadow[v][e] = '0;  // DUT resets to zero too
      end
    end
    repeat (5) @(posedge CLK);
    #2;
    nRST = 1'b1;

    @(negedge CLK);
    if (!cmd_ready) begin
      report_error("cmd_ready low after reset");
    end
    if (res_valid) begin
      report_error("res_valid high after reset");
    end
    @(posedge CLK);
    #2;
    beats_before = beats_checked;
    for (int v = 0; v < NUM_VREGS; v++) begin
      send_cmd(make_cmd(VOP_VID, v, 0, 0, elem_t'(v * 100), 0, VLMAX));
      wait_drain();
    end
    if (beats_checked - beats_before != NUM_VREGS * (VLMAX / NUM_LANES)) begin
      report_error($sformatf("%0d vid beats seen", beats_checked - beats_before));
    end
    finish_test("reset state and vid to every register");

    for (int v = 4; v < NUM_VREGS; v++) begin
      send_cmd(make_cmd(VOP_VMV_VX, v, 0, 0, $random(seed), 0, VLMAX));
      wait_drain();
    end
    for (int k = 0; k < 24; k++) begin
      send_random(vop_e'(3'(k)), 0, VLMAX);  // each op three times
      wait_drain();
    end
    finish_test("all operations, full length");

    send_random(VOP_VADD_VX, 3, 7);  // offsets 2, 4, 6
    wait_drain();
    send_random(VOP_VXOR_VV, 1, 5);
    wait_drain();
    send_random(VOP_VID, 0, 3);
    wait_drain();
    send_random(VOP_VSUB_VV, 5, 6);
    wait_drain();
    readback_all();  // untouched elements still match
    finish_test("vstart and odd vl");

    beats_before = res_beats;
    send_random(VOP_VADD_VV, 0, 0);
    wait_drain();
    send_random(VOP_VID, 5, 5);
    wait_drain();
    send_random(VOP_VMV_VX, 7, 3);
    wait_drain();
    repeat (4) @(posedge CLK);  // room for a stray beat
    #2;
    if (res_beats != beats_before) begin
      report_error("empty commands produced result beats");
    end
    finish_test("empty commands");

    bp_on = 1'b1;
    for (int k = 0; k < 24; k++) begin
      send_random(vop_e'(3'($random(seed))), 0, VLMAX);
      wait_drain();
    end
    readback_all();
    bp_on = 1'b0;
    finish_test("random back-pressure");

    for (int k = 0; k < 16; k++) begin
      send_random(vop_e'(3'($random(seed))), k % 3, VLMAX - (k % 2));  // valid never drops
    end
    wait_drain();
    readback_all();
    finish_test("back-to-back commands");

    $display("summary: %0d tests, %0d beats checked, %0d errors",
             test_no - 1, beats_checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: flist.f
vec_pkg.sv
vec_elem_seq.sv
vec_regfile.sv
vec_lane_alu.sv
vec_exec_top.sv
tb_vec_exec.sv

// File: Makefile
# Verilator build and run of the vector execution slice testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_exec
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
